/* hw/ldpc_node_pkg.sv */
package ldpc_node_pkg;

  localparam int cMAX_DEG    = 8;                   // max edges per check node
  localparam int cDEG_W      = 3;                   // degree and edge index width
  localparam int cMAG_W      = 7;                   // unsigned magnitude width
  localparam int cVAL_W      = cMAG_W + 1;          // signed edge value, always fits
  localparam int cREC_DEPTH  = 4;                   // pending records
  localparam int cRSLT_DEPTH = 16;                  // restored edges waiting for host

  // compressed check node record, low 28 bits of a bus word
  typedef struct packed {
    logic [cMAX_DEG-1:0] signs;                     // one sign per edge, bit n is edge n
    logic [cMAG_W-1:0]   min2;                      // second smallest magnitude
    logic [cMAG_W-1:0]   min1;                      // smallest magnitude
    logic [cDEG_W-1:0]   min_idx;                   // edge holding min1
    logic [cDEG_W-1:0]   num_m1;                    // degree minus one
  } node_rec_t;

  // one restored edge message
  typedef struct packed {
    logic                     valid;                // low when read hit empty fifo
    logic [cDEG_W-1:0]        idx;                  // edge index within record
    logic signed [cVAL_W-1:0] value;                // signed check to variable msg
  } edge_t;

  typedef struct packed {
    logic rec_full;                                 // host must wait on record writes
    logic rslt_empty;                               // nothing to pop
    logic busy;                                     // controller is emitting edges
    logic rec_empty;                                // no record queued
  } status_t;

endpackage

/* hw/ldpc_bus_pkg.sv */
package ldpc_bus_pkg;

  localparam int cWB_AW = 2;                        // word address width
  localparam int cWB_DW = 32;                       // data bus width

  // register map, word addresses
  localparam logic [cWB_AW-1:0] cADR_REC    = 2'd0; // write pushes one record
  localparam logic [cWB_AW-1:0] cADR_RSLT   = 2'd1; // read pops one edge
  localparam logic [cWB_AW-1:0] cADR_STATUS = 2'd2; // read only status bits

  // master to slave, held stable until ack
  typedef struct packed {
    logic              cyc;                         // bus cycle in progress
    logic              stb;                         // this slave selected
    logic              we;                          // write when high
    logic [cWB_AW-1:0] adr;                         // word address
    logic [cWB_DW-1:0] dat;                         // write data
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic              ack;                         // single cycle terminate
    logic [cWB_DW-1:0] dat;                         // read data, valid with ack
  } wb_rsp_t;

endpackage

/* hw/ldpc_node_fifo.sv */
`timescale 1ns/1ps

module ldpc_node_fifo #(
  parameter int pWIDTH = 8,
  parameter int pDEPTH = 4                          // power of two, pointers wrap freely
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              push,
  input  logic              pop,
  input  logic [pWIDTH-1:0] wdat,
  output logic [pWIDTH-1:0] rdat,
  output logic              empty,
  output logic              full,
  output logic              afull
);

  localparam int cPTR_W = $clog2(pDEPTH);
  localparam int cCNT_W = $clog2(pDEPTH + 1);

  logic [pWIDTH-1:0] mem [pDEPTH];                  // storage, no reset needed
  logic [cPTR_W-1:0] wptr;
  logic [cPTR_W-1:0] rptr;
  logic [cCNT_W-1:0] cnt;                           // occupied entries

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr <= '0;
      rptr <= '0;
      cnt  <= '0;
    end else begin
      if (push) wptr <= wptr + 1'b1;
      if (pop)  rptr <= rptr + 1'b1;
      case ({push, pop})
        2'b10   : cnt <= cnt + 1'b1;
        2'b01   : cnt <= cnt - 1'b1;
        default : cnt <= cnt;                       // both or neither, level unchanged
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (push) mem[wptr] <= wdat;
  end

  assign rdat  = mem[rptr];                         // head always visible, fwft
  assign empty = (cnt == '0);
  assign full  = (cnt == cCNT_W'(pDEPTH));
  assign afull = (cnt >= cCNT_W'(pDEPTH - 1));      // fewer than two free slots

  a_no_overflow  : assert property (@(posedge iclk) disable iff (ireset) push |-> !full)
    else $error("fifo push while full");
  a_no_underflow : assert property (@(posedge iclk) disable iff (ireset) pop |-> !empty)
    else $error("fifo pop while empty");

endmodule

/* hw/ldpc_node_wb_regs.sv */
`timescale 1ns/1ps

module ldpc_node_wb_regs (
  input  logic                    iclk,
  input  logic                    ireset,
  input  ldpc_bus_pkg::wb_req_t   wb_i,
  output ldpc_bus_pkg::wb_rsp_t   wb_o,
  output logic                    rec_push,
  output ldpc_node_pkg::node_rec_t rec_wdat,
  input  logic                    rec_full,
  output logic                    rslt_pop,
  input  ldpc_node_pkg::edge_t    rslt_head,
  input  logic                    rslt_empty,
  input  ldpc_node_pkg::status_t  stat
);

  logic                           ack_q;            // registered ack, one cycle wide
  logic [ldpc_bus_pkg::cWB_DW-1:0] dat_q;           // read data captured with ack
  logic                           req;              // new access not yet acked
  logic                           wr_rec;           // write aimed at record fifo
  logic                           rd_rslt;          // read aimed at result fifo
  logic                           ack_d;
  ldpc_node_pkg::edge_t           rslt_word;        // head as seen by host

  // ack_q masks the cycle where the master still shows the old access
  assign req     = wb_i.cyc & wb_i.stb & !ack_q;
  assign wr_rec  = req & wb_i.we & (wb_i.adr == ldpc_bus_pkg::cADR_REC);
  assign rd_rslt = req & !wb_i.we & (wb_i.adr == ldpc_bus_pkg::cADR_RSLT);

  assign rec_push = wr_rec & !rec_full;             // push on the ack edge
  assign rslt_pop = rd_rslt & !rslt_empty;          // pop on the ack edge, never when empty
  assign ack_d    = req & !(wr_rec & rec_full);     // full fifo stretches the write

  assign rec_wdat = ldpc_node_pkg::node_rec_t'(wb_i.dat[$bits(ldpc_node_pkg::node_rec_t)-1:0]);

  always_comb begin
    rslt_word = rslt_head;                          // stored edges carry valid set
    if (rslt_empty) begin
      rslt_word = '0;                               // empty read, valid stays low
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  always_ff @(posedge iclk) begin
    if (req & !wb_i.we) begin
      case (wb_i.adr)
        ldpc_bus_pkg::cADR_RSLT   : dat_q <= 32'(rslt_word);
        ldpc_bus_pkg::cADR_STATUS : dat_q <= 32'(stat);
        default                   : dat_q <= '0;   // unmapped reads return zero
      endcase
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = dat_q;

  // classic master keeps an unanswered request steady until ack
  a_req_held : assert property (@(posedge iclk) disable iff (ireset)
    (wb_i.cyc && wb_i.stb && !wb_o.ack) |=>
      (wb_o.ack || (wb_i.cyc && wb_i.stb && $stable(wb_i))))
    else $error("wishbone request dropped or changed before ack");

endmodule

/* hw/ldpc_dec_node_restore_ctrl.sv */
`timescale 1ns/1ps

module ldpc_dec_node_restore_ctrl (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             iclkena,
  input  logic                             rdy,     // record fifo not empty
  input  ldpc_node_pkg::node_rec_t         rec,     // record fifo head
  output logic                             pop,
  output logic                             rd,
  output logic [ldpc_node_pkg::cDEG_W-1:0] idx,
  output ldpc_node_pkg::node_rec_t         cur      // record being expanded
);

  typedef enum logic {
    cIDLE,
    cDO
  } state_t;

  state_t state;

  struct packed {
    logic                             done;         // last edge of record now on idx
    logic [ldpc_node_pkg::cDEG_W-1:0] value;        // edges left after this one
  } cnt;

  logic load_cnt;
  logic work_done;

  assign work_done = cnt.done & !rdy;               // nothing queued behind this record
  assign load_cnt  = ((state == cIDLE) & rdy) | ((state == cDO) & cnt.done & rdy);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= cIDLE;
    end else if (iclkena) begin
      case (state)
        cIDLE   : state <= rdy ? cDO : cIDLE;
        cDO     : state <= work_done ? cIDLE : cDO;
        default : state <= cIDLE;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (load_cnt) begin
        cnt.value <= rec.num_m1;
        cnt.done  <= (rec.num_m1 == '0);            // degree one record
        idx       <= '0;
        cur       <= rec;                           // latch so fifo can advance now
      end else if (state == cDO) begin
        cnt.value <= cnt.value - 1'b1;
        cnt.done  <= (cnt.value == 1);
        idx       <= idx + 1'b1;
      end
    end
  end

  assign pop = load_cnt & iclkena;                  // head consumed on the load edge
  assign rd  = (state == cDO);

  a_idx_range : assert property (@(posedge iclk) disable iff (ireset)
    rd |-> (idx <= cur.num_m1))
    else $error("edge index beyond record degree");

endmodule

/* hw/ldpc_node_restore_unit.sv */
`timescale 1ns/1ps

module ldpc_node_restore_unit (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             iclkena,
  input  logic                             rd,
  input  logic [ldpc_node_pkg::cDEG_W-1:0] idx,
  input  ldpc_node_pkg::node_rec_t         cur,
  output logic                             push,
  output ldpc_node_pkg::edge_t             rslt
);

  logic [ldpc_node_pkg::cMAG_W-1:0]        mag;     // selected magnitude
  logic                                    neg;     // sign of this edge
  logic signed [ldpc_node_pkg::cVAL_W-1:0] mag_s;   // magnitude as positive value
  logic signed [ldpc_node_pkg::cVAL_W-1:0] val;     // signed result before register
  logic                                    push_q;
  ldpc_node_pkg::edge_t                    edge_q;

  // min-sum restore, the min1 edge gets the other min
  assign mag   = (idx == cur.min_idx) ? cur.min2 : cur.min1;
  assign neg   = cur.signs[idx];
  assign mag_s = $signed({1'b0, mag});              // 7 bit magnitude never overflows 8 bit
  assign val   = neg ? -mag_s : mag_s;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      push_q <= 1'b0;
    end else if (iclkena) begin
      push_q <= rd;                                 // one enabled cycle behind rd
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      edge_q.valid <= 1'b1;                         // everything pushed is real data
      edge_q.idx   <= idx;
      edge_q.value <= val;
    end
  end

  // held edge is pushed only once the stall clears
  assign push = push_q & iclkena;
  assign rslt = edge_q;

endmodule

/* hw/ldpc_node_restore_top.sv */
`timescale 1ns/1ps

module ldpc_node_restore_top (
  input  logic                  iclk,
  input  logic                  ireset,
  input  ldpc_bus_pkg::wb_req_t wb_i,
  output ldpc_bus_pkg::wb_rsp_t wb_o
);

  localparam int cREC_W  = $bits(ldpc_node_pkg::node_rec_t);
  localparam int cEDGE_W = $bits(ldpc_node_pkg::edge_t);

  // decode side
  logic                             rec_push;
  ldpc_node_pkg::node_rec_t         rec_wdat;
  logic                             rec_full;
  logic                             rec_empty;
  ldpc_node_pkg::node_rec_t         rec_head;
  logic                             rslt_pop;
  ldpc_node_pkg::edge_t             rslt_head;
  logic                             rslt_empty;
  logic                             rslt_afull;
  ldpc_node_pkg::status_t           stat;

  // execute side
  logic                             clkena;
  logic                             rec_pop;
  logic                             rd;
  logic [ldpc_node_pkg::cDEG_W-1:0] idx;
  ldpc_node_pkg::node_rec_t         cur;
  logic                             rslt_push;
  ldpc_node_pkg::edge_t             rslt_edge;

  assign clkena = !rslt_afull;                      // keep room for the edge in flight

  assign stat.rec_full   = rec_full;
  assign stat.rslt_empty = rslt_empty;
  assign stat.busy       = rd;
  assign stat.rec_empty  = rec_empty;

  ldpc_node_wb_regs u_regs (
    .iclk(iclk), .ireset(ireset), .wb_i(wb_i), .wb_o(wb_o),
    .rec_push(rec_push), .rec_wdat(rec_wdat), .rec_full(rec_full),
    .rslt_pop(rslt_pop), .rslt_head(rslt_head), .rslt_empty(rslt_empty), .stat(stat)
  );

  ldpc_node_fifo #(.pWIDTH(cREC_W), .pDEPTH(ldpc_node_pkg::cREC_DEPTH)) u_rec_fifo (
    .iclk(iclk), .ireset(ireset), .push(rec_push), .pop(rec_pop),
    .wdat(rec_wdat), .rdat(rec_head), .empty(rec_empty), .full(rec_full), .afull()
  );

  ldpc_dec_node_restore_ctrl u_ctrl (
    .iclk(iclk), .ireset(ireset), .iclkena(clkena), .rdy(!rec_empty), .rec(rec_head),
    .pop(rec_pop), .rd(rd), .idx(idx), .cur(cur)
  );

  ldpc_node_restore_unit u_unit (
    .iclk(iclk), .ireset(ireset), .iclkena(clkena), .rd(rd), .idx(idx), .cur(cur),
    .push(rslt_push), .rslt(rslt_edge)
  );

  ldpc_node_fifo #(.pWIDTH(cEDGE_W), .pDEPTH(ldpc_node_pkg::cRSLT_DEPTH)) u_rslt_fifo (
    .iclk(iclk), .ireset(ireset), .push(rslt_push), .pop(rslt_pop),
    .wdat(rslt_edge), .rdat(rslt_head), .empty(rslt_empty), .full(), .afull(rslt_afull)
  );

endmodule

/* tests/ldpc_node_restore_tb.sv */
`timescale 1ns/1ps

module ldpc_node_restore_tb;

  localparam int cFIXED = 6;                          // hand written rows
  localparam int cROWS  = cFIXED + 16;                // plus random rows
  localparam int cLIMIT = 40 * cROWS + 500;           // cycle budget for the whole run

  localparam ldpc_node_pkg::status_t cIDLE_STAT = '{rec_full: 1'b0, rslt_empty: 1'b1,
                                                    busy: 1'b0, rec_empty: 1'b1};

  logic                     iclk = 1'b0;
  logic                     ireset;
  ldpc_bus_pkg::wb_req_t    wb_i;
  ldpc_bus_pkg::wb_rsp_t    wb_o;

  ldpc_node_pkg::node_rec_t recs [cROWS];             // stimulus table
  ldpc_node_pkg::edge_t     exp_q [$];                // edges still owed by the DUT
  integer                   seed = 32'h69d9_d6ad;
  int                       cycles = 0;
  int                       errors = 0;
  int                       checks = 0;
  int                       tests = 0;
  int                       test_err = 0;             // error count at start of test

  ldpc_node_restore_top uut (.iclk(iclk), .ireset(ireset), .wb_i(wb_i), .wb_o(wb_o));

  always #50 iclk = ~iclk;

  always @(posedge iclk) begin
    cycles <= cycles + 1;
    if (cycles >= cLIMIT) begin
      $display("run stopped after %0d cycles, the DUT did not finish", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // one classic cycle, driven on the falling edge, ends at ack
  task automatic bus_cycle(input logic is_wr, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int wait_n;
    wait_n = 0;
    @(negedge iclk);
    wb_i = '{cyc: 1'b1, stb: 1'b1, we: is_wr, adr: adr, dat: wdat};
    do begin
      @(negedge iclk);
      wait_n++;
    end while (!wb_o.ack && wait_n < 200);
    rdat = wb_o.dat;                                  // read data comes with ack
    wb_i = '0;
    if (!wb_o.ack) begin
      $display("no ack from the DUT for a bus access at address %0d", adr);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused_dat;
    bus_cycle(1'b1, adr, wdat, unused_dat);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, '0, rdat);
  endtask

  task automatic check_edge(input string name, input ldpc_node_pkg::edge_t exp,
                            input ldpc_node_pkg::edge_t act);
    checks++;
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input string name, input ldpc_node_pkg::status_t exp,
                              input ldpc_node_pkg::status_t act);
    checks++;
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // min-sum restore rule, min1 edge gets min2, sign bit negates
  function automatic ldpc_node_pkg::edge_t model_edge(input ldpc_node_pkg::node_rec_t r,
                                                      input int i);
    int                   m;
    ldpc_node_pkg::edge_t e;
    m = (i == int'(r.min_idx)) ? int'(r.min2) : int'(r.min1);
    if (r.signs[i]) m = -m;
    e.valid = 1'b1;
    e.idx   = 3'(i);
    e.value = m[7:0];                                 // two's complement, magnitudes fit
    return e;
  endfunction

  task automatic write_record(input ldpc_node_pkg::node_rec_t r);
    wb_write(ldpc_bus_pkg::cADR_REC, {4'b0, r});
    for (int i = 0; i <= int'(r.num_m1); i++) exp_q.push_back(model_edge(r, i));
  endtask

  // retry empty reads until the next edge shows up
  task automatic read_edge(input string name, output ldpc_node_pkg::edge_t got,
                           output bit found);
    logic [31:0] d;
    int          tries;
    found = 1'b0;
    for (tries = 0; tries < 40 && !found; tries++) begin
      wb_read(ldpc_bus_pkg::cADR_RSLT, d);
      got   = ldpc_node_pkg::edge_t'(d[11:0]);
      found = got.valid;
    end
    if (!found) begin
      $display("%s: an expected result never came out of the DUT", name);
      errors++;
    end
  endtask

  task automatic drain(input string name);
    ldpc_node_pkg::edge_t got;
    bit                   found;
    while (exp_q.size() > 0) begin
      read_edge(name, got, found);
      if (found) check_edge(name, exp_q.pop_front(), got);
      else exp_q.delete();                            // give up on the rest
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_err) $display("test %s: passed", name);
    else $display("test %s: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  initial begin
    logic [31:0]            d;
    logic [31:0]            a;
    logic [31:0]            b;
    int                     deg_m1;
    int                     next;
    bit                     stalled;
    ldpc_node_pkg::status_t st;
    wb_i   = '0;
    ireset = 1'b1;
    recs[0] = '{signs: 8'h00, min2: 7'd9, min1: 7'd5, min_idx: 3'd0, num_m1: 3'd0};
    recs[1] = '{signs: 8'h2a, min2: 7'd20, min1: 7'd3, min_idx: 3'd0, num_m1: 3'd5};
    recs[2] = '{signs: 8'h81, min2: 7'd127, min1: 7'd1, min_idx: 3'd7, num_m1: 3'd7};
    recs[3] = '{signs: 8'hff, min2: 7'd100, min1: 7'd64, min_idx: 3'd3, num_m1: 3'd7};
    recs[4] = '{signs: 8'h05, min2: 7'd42, min1: 7'd42, min_idx: 3'd2, num_m1: 3'd3};
    recs[5] = '{signs: 8'h07, min2: 7'd0, min1: 7'd0, min_idx: 3'd1, num_m1: 3'd2};
    for (int r = cFIXED; r < cROWS; r++) begin
      a      = $random(seed);
      b      = $random(seed);
      deg_m1 = 3 + int'(a[10:8]) % 5;                 // degree 4..8 so the fifo fills
      recs[r].num_m1  = 3'(deg_m1);
      recs[r].min_idx = 3'(int'(b[10:8]) % (deg_m1 + 1));
      recs[r].min1    = (a[6:0] < b[6:0]) ? a[6:0] : b[6:0];
      recs[r].min2    = (a[6:0] < b[6:0]) ? b[6:0] : a[6:0];
      recs[r].signs   = a[23:16];
    end
    repeat (4) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    wb_read(ldpc_bus_pkg::cADR_STATUS, d);
    check_status("reset_status", cIDLE_STAT, ldpc_node_pkg::status_t'(d[3:0]));
    wb_read(ldpc_bus_pkg::cADR_RSLT, d);
    check_edge("reset_empty_read", '0, ldpc_node_pkg::edge_t'(d[11:0]));
    finish_test("reset");

    for (int r = 0; r < cFIXED; r++) begin            // one record in flight at a time
      write_record(recs[r]);
      drain($sformatf("single_row%0d", r));
      finish_test($sformatf("single_row%0d", r));
    end

    for (int r = 0; r < cFIXED; r++) write_record(recs[r]);
    drain("burst");
    finish_test("burst");

    stalled = 1'b0;
    next    = cFIXED;
    while (next < cROWS) begin                        // no reads until the records back up
      wb_read(ldpc_bus_pkg::cADR_STATUS, d);
      st = ldpc_node_pkg::status_t'(d[3:0]);
      if (st.rec_full) begin
        stalled = 1'b1;
        drain("backpressure");
      end else begin
        write_record(recs[next]);
        next++;
      end
    end
    drain("backpressure");
    if (!stalled) begin
      $display("backpressure: the record FIFO never filled, no stall was seen");
      errors++;
    end
    finish_test("backpressure");

    wb_read(ldpc_bus_pkg::cADR_RSLT, d);
    check_edge("final_empty_read", '0, ldpc_node_pkg::edge_t'(d[11:0]));
    wb_read(ldpc_bus_pkg::cADR_STATUS, d);
    check_status("final_status", cIDLE_STAT, ldpc_node_pkg::status_t'(d[3:0]));
    finish_test("final");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

/* vlog.f */
hw/ldpc_node_pkg.sv
hw/ldpc_bus_pkg.sv
hw/ldpc_node_fifo.sv
hw/ldpc_node_wb_regs.sv
hw/ldpc_dec_node_restore_ctrl.sv
hw/ldpc_node_restore_unit.sv
hw/ldpc_node_restore_top.sv
tests/ldpc_node_restore_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module ldpc_node_restore_tb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: no errors" sim.log; then
  exit 0
fi
exit 1
